// ==== smartnic_lite.f ====
design/smartnic_pkg.sv
design/igr_arbiter.sv
design/pkt_fifo.sv
design/egr_demux.sv
design/smartnic_lite.sv
tb/tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the smartnic_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb -f smartnic_lite.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

// ==== tb/tb.sv ====
`timescale 1ns/100ps

module tb import smartnic_pkg::*; ();

    localparam int SEED       = 41555;
    // About 50 packets of up to 16 words, at most a few thousand cycles with stalls
    localparam int MAX_CYCLES = 20000;

    logic      clk;
    logic      rst_n;
    logic      cmac_rx_tvalid;
    igr_word_t cmac_rx;
    logic      cmac_rx_tready;
    logic      adpt_tx_tvalid;
    igr_word_t adpt_tx;
    logic      adpt_tx_tready;
    logic      cmac_tx_tvalid;
    egr_word_t cmac_tx;
    logic      cmac_tx_tready;
    logic      adpt_rx_tvalid;
    egr_word_t adpt_rx;
    logic      adpt_rx_tready;

    // Expected words, indexed by {egress port, source port}
    egr_word_t exp_q [4][$];
    logic      in_pkt [2];
    port_t     pkt_src [2];
    logic      stall_en;
    logic      gap_en;
    int        errors;
    int        words_seen;
    int        tests_run;
    int        cycles;

    smartnic_lite dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Egress back-pressure
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            cmac_tx_tready = ($urandom_range(1, 0) == 1);
            adpt_rx_tready = ($urandom_range(1, 0) == 1);
        end else begin
            cmac_tx_tready = 1'b1;
            adpt_rx_tready = 1'b1;
        end
    end

    // ====================
    // Checker
    // ====================
    // Sampled mid-cycle, where valid and ready are settled for the next edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_egress(PORT_CMAC, cmac_tx_tvalid, cmac_tx_tready, cmac_tx);
            check_egress(PORT_HOST, adpt_rx_tvalid, adpt_rx_tready, adpt_rx);
        end
    end

    task automatic show_error(input string sig, input logic [63:0] exp, input logic [63:0] got);
        $display("Error at %0t: %s expected %0h, got %0h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic check_egress(input port_t egr, input logic vld, input logic rdy,
                                input egr_word_t got);
        string      nm;
        egr_word_t  exp;
        logic [1:0] idx;
        nm = (egr == PORT_CMAC) ? "cmac_tx" : "adpt_rx";
        if (in_pkt[egr] && rdy && !vld) begin
            $display("%s dropped tvalid inside a packet at %0t", nm, $time);
            errors++;
        end
        if (vld && rdy) begin
            words_seen++;
            // Words of two packets must not mix
            if (in_pkt[egr] && got.tid != pkt_src[egr]) begin
                show_error({nm, ".tid"}, 64'(pkt_src[egr]), 64'(got.tid));
            end
            idx = {egr, got.tid};
            if (exp_q[idx].size() == 0) begin
                $display("%s delivered a word that no packet should send, at %0t", nm, $time);
                errors++;
            end else begin
                exp = exp_q[idx].pop_front();
                if (got.tdata != exp.tdata) begin
                    show_error({nm, ".tdata"}, exp.tdata, got.tdata);
                end
                if (got.tkeep != exp.tkeep) begin
                    show_error({nm, ".tkeep"}, 64'(exp.tkeep), 64'(got.tkeep));
                end
                if (got.tlast != exp.tlast) begin
                    show_error({nm, ".tlast"}, 64'(exp.tlast), 64'(got.tlast));
                end
            end
            in_pkt[egr]  = !got.tlast;
            pkt_src[egr] = got.tid;
        end
    endtask

    // ====================
    // Drivers
    // ====================
    function automatic port_t egress_of(input port_t src, input igr_tdest_t code);
        if (code == IGR_TO_WIRE) begin
            return PORT_CMAC;
        end
        if (code == IGR_TO_HOST) begin
            return PORT_HOST;
        end
        // Bypass turns back toward the other side
        return (src == PORT_CMAC) ? PORT_HOST : PORT_CMAC;
    endfunction

    function automatic int rand_len();
        return int'($urandom_range(MAX_PKT_WORDS, 1));
    endfunction

    task automatic idle_source(input port_t src, input int n);
        if (src == PORT_CMAC) begin
            cmac_rx_tvalid = 1'b0;
        end else begin
            adpt_tx_tvalid = 1'b0;
        end
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds the word until the DUT takes it
    task automatic drive_word(input port_t src, input igr_word_t w);
        logic taken;
        taken = 1'b0;
        if (src == PORT_CMAC) begin
            cmac_rx_tvalid = 1'b1;
            cmac_rx        = w;
        end else begin
            adpt_tx_tvalid = 1'b1;
            adpt_tx        = w;
        end
        while (!taken) begin
            @(negedge clk);
            taken = (src == PORT_CMAC) ? cmac_rx_tready : adpt_tx_tready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_packet(input port_t src, input igr_tdest_t code, input int len,
                               input logic bad);
        igr_word_t           w;
        egr_word_t           e;
        port_t               dest;
        logic                kept;
        int                  err_at;
        logic [KEEP_WID-1:0] keep_last;
        dest      = egress_of(src, code);
        kept      = (code != IGR_DROP) && !bad;
        err_at    = bad ? int'($urandom_range(len - 1, 0)) : -1;
        keep_last = KEEP_WID'($urandom_range(255, 1));
        for (int i = 0; i < len; i++) begin
            w.tdata     = {$urandom, $urandom};
            w.tkeep     = (i == len - 1) ? keep_last : '1;
            w.tlast     = (i == len - 1);
            // Only the first word carries a meaningful code
            w.tdest     = (i == 0) ? code : igr_tdest_t'(2'($urandom_range(3, 0)));
            w.tuser_err = (i == err_at);
            if (kept) begin
                e.tdata = w.tdata;
                e.tkeep = w.tkeep;
                e.tlast = w.tlast;
                e.tid   = src;
                exp_q[{dest, src}].push_back(e);
            end
            drive_word(src, w);
            if (gap_en && $urandom_range(3, 0) == 0) begin
                idle_source(src, int'($urandom_range(3, 1)));
            end
        end
        idle_source(src, 0);
    endtask

    task automatic send_burst(input port_t src, input int n, input logic with_bad);
        logic bad;
        repeat (n) begin
            bad = with_bad && ($urandom_range(3, 0) == 0);
            send_packet(src, igr_tdest_t'(2'($urandom_range(2, 0))), rand_len(), bad);
        end
    endtask

    task automatic wait_drained();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
            @(posedge clk);
        end
        // Idle cycles expose any stray word
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (cmac_tx_tvalid || adpt_rx_tvalid || cmac_rx_tready || adpt_tx_tready) begin
            $display("Stream outputs were not idle after reset at %0t", $time);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_routing();
        int err0;
        err0 = errors;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < 3; c++) begin
                send_packet(port_t'(s), igr_tdest_t'(c), rand_len(), 1'b0);
                wait_drained();
            end
        end
        end_test("routing of single packets", err0);
    endtask

    task automatic test_discard();
        int err0;
        err0 = errors;
        for (int s = 0; s < 2; s++) begin
            send_packet(port_t'(s), IGR_TO_WIRE, rand_len(), 1'b1);
            send_packet(port_t'(s), IGR_DROP, rand_len(), 1'b0);
            send_packet(port_t'(s), IGR_BYPASS, rand_len(), 1'b1);
            send_packet(port_t'(s), IGR_TO_HOST, rand_len(), 1'b0);
            wait_drained();
        end
        end_test("errored and dropped packets", err0);
    endtask

    task automatic test_contention();
        int err0;
        err0 = errors;
        fork
            send_burst(PORT_CMAC, 8, 1'b0);
            send_burst(PORT_HOST, 8, 1'b0);
        join
        wait_drained();
        end_test("bursts from both sources", err0);
    endtask

    task automatic test_stalls();
        int err0;
        err0     = errors;
        stall_en = 1'b1;
        gap_en   = 1'b1;
        fork
            send_burst(PORT_CMAC, 10, 1'b1);
            send_burst(PORT_HOST, 10, 1'b1);
        join
        wait_drained();
        stall_en = 1'b0;
        gap_en   = 1'b0;
        end_test("egress stalls and ingress gaps", err0);
    endtask

    initial begin
        void'($urandom(SEED));
        $timeformat(-9, 0, " ns", 0);
        errors         = 0;
        words_seen     = 0;
        tests_run      = 0;
        cycles         = 0;
        stall_en       = 1'b0;
        gap_en         = 1'b0;
        in_pkt         = '{1'b0, 1'b0};
        pkt_src        = '{PORT_CMAC, PORT_CMAC};
        cmac_rx_tvalid = 1'b0;
        cmac_rx        = '0;
        adpt_tx_tvalid = 1'b0;
        adpt_tx        = '0;
        cmac_tx_tready = 1'b1;
        adpt_rx_tready = 1'b1;
        apply_reset();
        test_routing();
        test_discard();
        test_contention();
        test_stalls();
        $display("Done: %0d tests, %0d words checked, %0d errors", tests_run, words_seen, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb

// ==== design/smartnic_lite.sv ====
`timescale 1ns/100ps

module smartnic_lite import smartnic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmac_rx_tvalid,
    input  igr_word_t cmac_rx,
    output logic      cmac_rx_tready,

    input  logic      adpt_tx_tvalid,
    input  igr_word_t adpt_tx,
    output logic      adpt_tx_tready,

    output logic      cmac_tx_tvalid,
    output egr_word_t cmac_tx,
    input  logic      cmac_tx_tready,

    output logic      adpt_rx_tvalid,
    output egr_word_t adpt_rx,
    input  logic      adpt_rx_tready
);

    // Arbiter to buffer
    logic      buf_tvalid;
    buf_word_t buf_word;
    logic      buf_tready;

    // Buffer to demux
    logic      head_tvalid;
    buf_word_t head_word;
    logic      head_tready;

    // ====================
    // Datapath
    // ====================
    igr_arbiter u_igr_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmac_rx_tvalid (cmac_rx_tvalid),
        .cmac_rx        (cmac_rx),
        .cmac_rx_tready (cmac_rx_tready),
        .adpt_tx_tvalid (adpt_tx_tvalid),
        .adpt_tx        (adpt_tx),
        .adpt_tx_tready (adpt_tx_tready),
        .buf_tvalid     (buf_tvalid),
        .buf_word       (buf_word),
        .buf_tready     (buf_tready)
    );

    pkt_fifo u_pkt_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .buf_tvalid  (buf_tvalid),
        .buf_word    (buf_word),
        .buf_tready  (buf_tready),
        .head_tvalid (head_tvalid),
        .head_word   (head_word),
        .head_tready (head_tready)
    );

    egr_demux u_egr_demux (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_tvalid    (head_tvalid),
        .head_word      (head_word),
        .head_tready    (head_tready),
        .cmac_tx_tvalid (cmac_tx_tvalid),
        .cmac_tx        (cmac_tx),
        .cmac_tx_tready (cmac_tx_tready),
        .adpt_rx_tvalid (adpt_rx_tvalid),
        .adpt_rx        (adpt_rx),
        .adpt_rx_tready (adpt_rx_tready)
    );

endmodule : smartnic_lite

// ==== design/egr_demux.sv ====
`timescale 1ns/100ps

module egr_demux import smartnic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      head_tvalid,
    input  buf_word_t head_word,
    output logic      head_tready,

    output logic      cmac_tx_tvalid,
    output egr_word_t cmac_tx,
    input  logic      cmac_tx_tready,

    output logic      adpt_rx_tvalid,
    output egr_word_t adpt_rx,
    input  logic      adpt_rx_tready
);

    egr_word_t egr_word;
    logic      to_cmac;

    // ====================
    // Steering
    // ====================
    assign to_cmac = (head_word.tdest == PORT_CMAC);

    assign cmac_tx_tvalid = head_tvalid && to_cmac;
    assign adpt_rx_tvalid = head_tvalid && !to_cmac;

    // Selected output alone pulls from the buffer
    assign head_tready = to_cmac ? cmac_tx_tready : adpt_rx_tready;

    // Routing fields stop here, source id goes on
    always_comb begin
        egr_word.tdata = head_word.tdata;
        egr_word.tkeep = head_word.tkeep;
        egr_word.tlast = head_word.tlast;
        egr_word.tid   = head_word.tid;
    end

    assign cmac_tx = egr_word;
    assign adpt_rx = egr_word;

    // ====================
    // Checks
    // ====================
    property p_hold(logic vld, logic rdy, egr_word_t word);
        @(posedge clk) disable iff (!rst_n)
        vld && !rdy |=> vld && $stable(word);
    endproperty

    // A stalled word stays put until taken
    a_cmac_hold: assert property (p_hold(cmac_tx_tvalid, cmac_tx_tready, cmac_tx));
    a_adpt_hold: assert property (p_hold(adpt_rx_tvalid, adpt_rx_tready, adpt_rx));

endmodule : egr_demux

// ==== design/pkt_fifo.sv ====
`timescale 1ns/100ps

module pkt_fifo import smartnic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      buf_tvalid,
    input  buf_word_t buf_word,
    output logic      buf_tready,

    output logic      head_tvalid,
    output buf_word_t head_word,
    input  logic      head_tready
);

    // ====================
    // Storage
    // ====================
    buf_word_t mem [FIFO_DEPTH];

    // One extra pointer bit tells full from empty
    logic [PTR_WID:0] wr_ptr;
    logic [PTR_WID:0] cmt_ptr;
    logic [PTR_WID:0] rd_ptr;

    logic [PTR_WID:0] used;
    logic [PTR_WID:0] cmt_used;
    logic             full;
    logic             wr_en;
    logic             rd_en;
    logic             pkt_end;
    logic             pkt_drop;

    assign used     = wr_ptr - rd_ptr;
    assign cmt_used = cmt_ptr - rd_ptr;
    assign full     = (used == (PTR_WID+1)'(FIFO_DEPTH));

    assign buf_tready = !full;
    assign wr_en      = buf_tvalid && buf_tready;
    assign pkt_end    = buf_word.tlast;
    assign pkt_drop   = buf_word.tlast && buf_word.discard;

    // Last word of a dropped packet is not stored
    always_ff @(posedge clk) begin
        if (wr_en && !pkt_drop) begin
            mem[wr_ptr[PTR_WID-1:0]] <= buf_word;
        end
    end

    // ====================
    // Pointers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (pkt_drop) begin
                // Rewind over the partial packet
                wr_ptr <= cmt_ptr;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmt_ptr <= '0;
        end else if (wr_en && pkt_end && !pkt_drop) begin
            cmt_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ====================
    // Read side
    // ====================
    // Only whole committed packets are visible
    assign head_tvalid = (rd_ptr != cmt_ptr);
    assign head_word   = mem[rd_ptr[PTR_WID-1:0]];
    assign rd_en       = head_tvalid && head_tready;

    // Fill stays within depth and the pointers stay in order
    a_ptr_order: assert property (@(posedge clk) disable iff (!rst_n)
        (used <= (PTR_WID+1)'(FIFO_DEPTH)) && (cmt_used <= used));

    // Rest of a committed packet is already stored
    a_pkt_gapless: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && !head_word.tlast |=> head_tvalid);

endmodule : pkt_fifo

// ==== design/igr_arbiter.sv ====
`timescale 1ns/100ps

module igr_arbiter import smartnic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmac_rx_tvalid,
    input  igr_word_t cmac_rx,
    output logic      cmac_rx_tready,

    input  logic      adpt_tx_tvalid,
    input  igr_word_t adpt_tx,
    output logic      adpt_tx_tready,

    output logic      buf_tvalid,
    output buf_word_t buf_word,
    input  logic      buf_tready
);

    // Packet ownership
    logic      busy;
    port_t     owner;
    port_t     last_src;
    port_t     sel;

    // Routing latched from the first word
    port_t     dest_q;
    logic      drop_q;
    logic      err_q;

    logic      in_valid;
    igr_word_t in_word;
    logic      out_ready;
    logic      in_xfer;
    port_t     first_dest;
    logic      first_drop;
    port_t     cur_dest;
    logic      cur_drop;
    logic      cur_err;

    // ====================
    // Grant
    // ====================
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (cmac_rx_tvalid && adpt_tx_tvalid) begin
            // Both waiting, so serve the one not served last
            sel = (last_src == PORT_CMAC) ? PORT_HOST : PORT_CMAC;
        end else if (adpt_tx_tvalid) begin
            sel = PORT_HOST;
        end else begin
            sel = PORT_CMAC;
        end
    end

    assign in_valid  = (sel == PORT_CMAC) ? cmac_rx_tvalid : adpt_tx_tvalid;
    assign in_word   = (sel == PORT_CMAC) ? cmac_rx : adpt_tx;
    assign out_ready = !buf_tvalid || buf_tready;
    assign in_xfer   = in_valid && out_ready;

    assign cmac_rx_tready = out_ready && (sel == PORT_CMAC) && (busy || cmac_rx_tvalid);
    assign adpt_tx_tready = out_ready && (sel == PORT_HOST) && (busy || adpt_tx_tvalid);

    // ====================
    // Destination
    // ====================
    always_comb begin
        first_drop = 1'b0;
        case (in_word.tdest)
            IGR_TO_WIRE: first_dest = PORT_CMAC;
            IGR_TO_HOST: first_dest = PORT_HOST;
            IGR_BYPASS:  first_dest = (sel == PORT_CMAC) ? PORT_HOST : PORT_CMAC;
            default: begin
                first_dest = sel;
                first_drop = 1'b1;
            end
        endcase
    end

    assign cur_dest = busy ? dest_q : first_dest;
    assign cur_drop = busy ? drop_q : first_drop;
    // Error on any word of the packet condemns the whole packet
    assign cur_err  = (busy && err_q) || in_word.tuser_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            owner    <= PORT_CMAC;
            last_src <= PORT_HOST;
            dest_q   <= PORT_CMAC;
            drop_q   <= 1'b0;
            err_q    <= 1'b0;
        end else if (in_xfer) begin
            busy   <= !in_word.tlast;
            owner  <= sel;
            dest_q <= cur_dest;
            drop_q <= cur_drop;
            err_q  <= cur_err;
            if (!busy) begin
                last_src <= sel;
            end
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_tvalid <= 1'b0;
        end else if (in_xfer) begin
            buf_tvalid <= 1'b1;
        end else if (buf_tready) begin
            buf_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            buf_word.tdata   <= in_word.tdata;
            buf_word.tkeep   <= in_word.tkeep;
            buf_word.tlast   <= in_word.tlast;
            buf_word.tid     <= sel;
            buf_word.tdest   <= cur_dest;
            buf_word.discard <= in_word.tlast && (cur_err || cur_drop);
        end
    end

    // No switch of source in the middle of a packet
    a_owner_held: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !(in_xfer && in_word.tlast) |=> busy && (owner == $past(owner)));

endmodule : igr_arbiter

// ==== design/smartnic_pkg.sv ====
package smartnic_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int DATA_WID      = 64;
    localparam int KEEP_WID      = DATA_WID / 8;
    localparam int FIFO_DEPTH    = 32;
    localparam int PTR_WID       = $clog2(FIFO_DEPTH);
    localparam int MAX_PKT_WORDS = FIFO_DEPTH / 2;

    // ====================
    // Codes
    // ====================
    typedef enum logic {
        PORT_CMAC = 1'b0,
        PORT_HOST = 1'b1
    } port_t;

    // Carried on the first word of each ingress packet
    typedef enum logic [1:0] {
        IGR_TO_WIRE = 2'h0,
        IGR_TO_HOST = 2'h1,
        IGR_BYPASS  = 2'h2,
        IGR_DROP    = 2'h3
    } igr_tdest_t;

    // ====================
    // Stream words
    // ====================
    typedef struct packed {
        logic [DATA_WID-1:0] tdata;
        logic [KEEP_WID-1:0] tkeep;
        logic                tlast;
        igr_tdest_t          tdest;
        logic                tuser_err;
    } igr_word_t;

    typedef struct packed {
        logic [DATA_WID-1:0] tdata;
        logic [KEEP_WID-1:0] tkeep;
        logic                tlast;
        port_t               tid;
        port_t               tdest;
        logic                discard;
    } buf_word_t;

    typedef struct packed {
        logic [DATA_WID-1:0] tdata;
        logic [KEEP_WID-1:0] tkeep;
        logic                tlast;
        port_t               tid;
    } egr_word_t;

endpackage : smartnic_pkg
